//--- include/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// address and data widths
`define CONV_NB_ADDRESS 10
`define CONV_NB_PIXEL   8
`define CONV_NB_COEF    8
// wide enough for 3 * 255 * 255
`define CONV_NB_RESULT  18

// unsigned kernel taps, y[n] = K0*x[n] + K1*x[n-1] + K2*x[n-2]
`define CONV_K0         3
`define CONV_K1         5
`define CONV_K2         2

// read address to write strobe, one memory cycle plus five engine stages
`define CONV_LATENCY    6

`endif

//--- src/convPkg.sv
`default_nettype none

`include "conv_config.svh"

package convPkg;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOAD    = 3'd1,
        PROCESS = 3'd2,
        DONE    = 3'd3,
        READOUT = 3'd4
    } fsmState_e;

    // write port of the output line memory
    typedef struct packed {
        logic [`CONV_NB_ADDRESS-1:0] addr;
        logic [`CONV_NB_RESULT-1:0]  data;
        logic                        en;
    } resultWrite_t;

    // write port of the input line memory
    typedef struct packed {
        logic [`CONV_NB_ADDRESS-1:0] addr;
        logic [`CONV_NB_PIXEL-1:0]   data;
        logic                        en;
    } pixelWrite_t;

    // pixel on its way into the engine
    typedef struct packed {
        logic [`CONV_NB_PIXEL-1:0] data;
        logic                      valid;
    } convSample_t;

    // filtered value leaving the engine
    typedef struct packed {
        logic [`CONV_NB_RESULT-1:0] data;
        logic                       valid;
    } convResult_t;

endpackage

`default_nettype wire

//--- src/imageMem.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module imageMem #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                                      i_CLK,
    input  wire [`CONV_NB_ADDRESS+DATA_WIDTH:0]      i_write,
    input  wire [`CONV_NB_ADDRESS-1:0]               i_readAdd,
    output logic [DATA_WIDTH-1:0]                    o_readData
);

    localparam int NB_ADD = `CONV_NB_ADDRESS;
    localparam int DEPTH  = 1 << NB_ADD;

    // same field layout as the write structs in convPkg
    typedef struct packed {
        logic [NB_ADD-1:0]     addr;
        logic [DATA_WIDTH-1:0] data;
        logic                  en;
    } memWrite_t;

    memWrite_t             memWrite;
    logic [DATA_WIDTH-1:0] lineMem [0:DEPTH-1];

    assign memWrite = memWrite_t'(i_write);

    always_ff @(posedge i_CLK) begin
        if (memWrite.en) begin
            lineMem[memWrite.addr] <= memWrite.data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge i_CLK) begin
        o_readData <= lineMem[i_readAdd];
    end

endmodule

`default_nettype wire

//--- src/convEngine.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module convEngine (
    input  wire                  i_CLK,
    input  wire                  i_reset,
    input  wire convPkg::convSample_t i_sample,
    output convPkg::convResult_t o_result
);

    import convPkg::*;

    localparam int NB_PIX  = `CONV_NB_PIXEL;
    localparam int NB_COEF = `CONV_NB_COEF;
    localparam int NB_RES  = `CONV_NB_RESULT;
    localparam int STAGES  = 5;

    localparam logic [NB_COEF-1:0] K0 = NB_COEF'(`CONV_K0);
    localparam logic [NB_COEF-1:0] K1 = NB_COEF'(`CONV_K1);
    localparam logic [NB_COEF-1:0] K2 = NB_COEF'(`CONV_K2);

    logic              prevValid;
    logic              passStart;
    logic [STAGES-1:0] validChain;

    // last two valid pixels
    logic [NB_PIX-1:0] hist1;
    logic [NB_PIX-1:0] hist2;

    logic [NB_PIX-1:0] tap0;
    logic [NB_PIX-1:0] tap1;
    logic [NB_PIX-1:0] tap2;
    logic [NB_RES-1:0] prod0;
    logic [NB_RES-1:0] prod1;
    logic [NB_RES-1:0] prod2;
    logic [NB_RES-1:0] partialSum;
    logic [NB_RES-1:0] prod2Dly;
    logic [NB_RES-1:0] fullSum;
    logic [NB_RES-1:0] resultData;

    // new pass begins when valid rises from low
    assign passStart = i_sample.valid & ~prevValid;

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            prevValid  <= 1'b0;
            validChain <= '0;
        end else begin
            prevValid  <= i_sample.valid;
            validChain <= {validChain[STAGES-2:0], i_sample.valid};
        end
    end

    // stage 1, tap window with zeros before the first pixel
    always_ff @(posedge i_CLK) begin
        if (i_sample.valid) begin
            tap0  <= i_sample.data;
            tap1  <= passStart ? '0 : hist1;
            tap2  <= passStart ? '0 : hist2;
            hist1 <= i_sample.data;
            hist2 <= passStart ? '0 : hist1;
        end
    end

    // stages 2 to 5
    always_ff @(posedge i_CLK) begin
        prod0      <= NB_RES'(tap0) * NB_RES'(K0);
        prod1      <= NB_RES'(tap1) * NB_RES'(K1);
        prod2      <= NB_RES'(tap2) * NB_RES'(K2);
        partialSum <= prod0 + prod1;
        prod2Dly   <= prod2;
        fullSum    <= partialSum + prod2Dly;
        resultData <= fullSum;
    end

    assign o_result = '{data: resultData, valid: validChain[STAGES-1]};

    // a result leaves exactly five cycles after its pixel entered
    validLatency: assert property (
        @(posedge i_CLK) disable iff (i_reset)
        o_result.valid == $past(i_sample.valid, STAGES)
    );

endmodule

`default_nettype wire

//--- src/blockFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module blockFsm (
    input  wire                          i_CLK,
    input  wire                          i_reset,
    input  wire [`CONV_NB_ADDRESS-1:0]   i_imgLength,
    input  wire                          i_load,
    input  wire                          i_SoP,
    input  wire                          i_valid,
    input  wire [`CONV_NB_PIXEL-1:0]     i_pixel,
    output convPkg::pixelWrite_t         o_pixelWrite,
    output logic [`CONV_NB_ADDRESS-1:0]  o_readAdd,
    output logic                         o_convValid,
    output logic [`CONV_NB_ADDRESS-1:0]  o_writeAdd,
    output logic [`CONV_NB_ADDRESS-1:0]  o_resultRead,
    output logic                         o_outValid,
    output logic                         o_changeBlock,
    output logic                         o_EoP,
    output convPkg::fsmState_e           o_state
);

    import convPkg::*;

    localparam int NB_ADD = `CONV_NB_ADDRESS;
    localparam int NB_PIX = `CONV_NB_PIXEL;
    localparam int LAT    = `CONV_LATENCY;
    localparam int NB_LAT = $clog2(LAT + 1);

    fsmState_e         state;
    logic              prevValid;
    logic              validRise;
    logic [NB_ADD-1:0] lastAdd;

    // shared address counter, meaning depends on the state
    logic [NB_ADD-1:0] counterAdd;
    logic [NB_ADD-1:0] writeAdd;
    logic [NB_LAT-1:0] latCount;
    logic              readIssue;
    logic              convValid;
    logic              changeBlock;
    logic              endOfProcess;
    logic              readPending;
    logic              outValid;

    logic              pixEn;
    logic [NB_ADD-1:0] pixAddr;
    logic [NB_PIX-1:0] pixData;
    logic [NB_ADD-1:0] readOutAdd;

    assign validRise = i_valid & ~prevValid;
    assign lastAdd   = i_imgLength - 1'b1;

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            state        <= IDLE;
            prevValid    <= 1'b0;
            counterAdd   <= '0;
            writeAdd     <= '0;
            latCount     <= '0;
            readIssue    <= 1'b0;
            convValid    <= 1'b0;
            changeBlock  <= 1'b0;
            endOfProcess <= 1'b0;
            readPending  <= 1'b0;
            outValid     <= 1'b0;
            pixEn        <= 1'b0;
        end else begin
            prevValid   <= i_valid;
            pixEn       <= 1'b0;
            changeBlock <= 1'b0;
            readPending <= 1'b0;
            outValid    <= readPending;
            // memory data shows up one cycle after its address
            convValid   <= readIssue;

            case (state)
                IDLE: begin
                    counterAdd <= '0;
                    writeAdd   <= '0;
                    latCount   <= '0;
                    if (i_load && !i_SoP) begin
                        state <= LOAD;
                    end else if (i_SoP && !i_load) begin
                        state     <= PROCESS;
                        readIssue <= 1'b1;
                    end
                end

                LOAD: begin
                    if (validRise) begin
                        pixEn      <= 1'b1;
                        counterAdd <= counterAdd + 1'b1;
                        if (counterAdd == lastAdd) begin
                            changeBlock <= 1'b1;
                            state       <= IDLE;
                        end
                    end
                end

                PROCESS: begin
                    // one read address per cycle
                    if (readIssue) begin
                        if (counterAdd == lastAdd) begin
                            readIssue <= 1'b0;
                        end else begin
                            counterAdd <= counterAdd + 1'b1;
                        end
                    end
                    // write side trails the reads by the pipeline latency
                    if (latCount < NB_LAT'(LAT)) begin
                        latCount <= latCount + 1'b1;
                    end else if (writeAdd == lastAdd) begin
                        changeBlock  <= 1'b1;
                        endOfProcess <= 1'b1;
                        state        <= DONE;
                    end else begin
                        writeAdd <= writeAdd + 1'b1;
                    end
                end

                DONE: begin
                    counterAdd <= '0;
                    if (!i_SoP) begin
                        state <= READOUT;
                    end
                end

                READOUT: begin
                    if (validRise && counterAdd != i_imgLength) begin
                        readPending <= 1'b1;
                        counterAdd  <= counterAdd + 1'b1;
                    end
                    // leave once the last value has been presented
                    if (outValid && counterAdd == i_imgLength) begin
                        endOfProcess <= 1'b0;
                        state        <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // pixel and readout address registers
    always_ff @(posedge i_CLK) begin
        if (state == LOAD && validRise) begin
            pixAddr <= counterAdd;
            pixData <= i_pixel;
        end
        if (state == READOUT && validRise) begin
            readOutAdd <= counterAdd;
        end
    end

    assign o_pixelWrite  = '{addr: pixAddr, data: pixData, en: pixEn};
    assign o_readAdd     = counterAdd;
    assign o_convValid   = convValid;
    assign o_writeAdd    = writeAdd;
    assign o_resultRead  = readOutAdd;
    assign o_outValid    = outValid;
    assign o_changeBlock = changeBlock;
    assign o_EoP         = endOfProcess;
    assign o_state       = state;

    changeBlockPulse: assert property (
        @(posedge i_CLK) disable iff (i_reset)
        o_changeBlock |=> !o_changeBlock
    );

    // write side stays inside the line
    writeAddInRange: assert property (
        @(posedge i_CLK) disable iff (i_reset)
        (state == PROCESS) |-> (o_writeAdd < i_imgLength)
    );

endmodule

`default_nettype wire

//--- src/convAccel.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module convAccel (
    input  wire                          i_CLK,
    input  wire                          i_reset,
    input  wire [`CONV_NB_ADDRESS-1:0]   i_imgLength,
    input  wire                          i_load,
    input  wire                          i_SoP,
    input  wire                          i_valid,
    input  wire [`CONV_NB_PIXEL-1:0]     i_pixel,
    output logic [`CONV_NB_RESULT-1:0]   o_pixelOut,
    output logic                         o_outValid,
    output logic                         o_changeBlock,
    output logic                         o_EoP,
    output logic                         o_busy
);

    import convPkg::*;

    localparam int NB_ADD = `CONV_NB_ADDRESS;
    localparam int NB_PIX = `CONV_NB_PIXEL;
    localparam int NB_RES = `CONV_NB_RESULT;

    pixelWrite_t       pixelWrite;
    resultWrite_t      resultWrite;
    convSample_t       sample;
    convResult_t       result;
    fsmState_e         state;
    logic [NB_ADD-1:0] readAdd;
    logic [NB_ADD-1:0] writeAdd;
    logic [NB_ADD-1:0] resultRead;
    logic [NB_PIX-1:0] inReadData;
    logic              convValid;

    blockFsm u_blockFsm (
        .i_CLK         (i_CLK),
        .i_reset       (i_reset),
        .i_imgLength   (i_imgLength),
        .i_load        (i_load),
        .i_SoP         (i_SoP),
        .i_valid       (i_valid),
        .i_pixel       (i_pixel),
        .o_pixelWrite  (pixelWrite),
        .o_readAdd     (readAdd),
        .o_convValid   (convValid),
        .o_writeAdd    (writeAdd),
        .o_resultRead  (resultRead),
        .o_outValid    (o_outValid),
        .o_changeBlock (o_changeBlock),
        .o_EoP         (o_EoP),
        .o_state       (state)
    );

    imageMem #(.DATA_WIDTH(NB_PIX)) u_inputMem (
        .i_CLK      (i_CLK),
        .i_write    (pixelWrite),
        .i_readAdd  (readAdd),
        .o_readData (inReadData)
    );

    // valid from the FSM lines up with the registered memory read
    assign sample = '{data: inReadData, valid: convValid};

    convEngine u_convEngine (
        .i_CLK    (i_CLK),
        .i_reset  (i_reset),
        .i_sample (sample),
        .o_result (result)
    );

    assign resultWrite = '{addr: writeAdd, data: result.data, en: result.valid};

    imageMem #(.DATA_WIDTH(NB_RES)) u_outputMem (
        .i_CLK      (i_CLK),
        .i_write    (resultWrite),
        .i_readAdd  (resultRead),
        .o_readData (o_pixelOut)
    );

    assign o_busy = (state != IDLE);

endmodule

`default_nettype wire

//--- tb/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic o_CLK
);

    initial o_CLK = 1'b0;

    always #(PERIOD_NS / 2.0) o_CLK = ~o_CLK;

endmodule

`default_nettype wire

//--- tb/convChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module convChecker (
    input  wire                          i_CLK,
    input  wire                          i_reset,
    input  wire [`CONV_NB_ADDRESS-1:0]   i_imgLength,
    input  wire                          i_load,
    input  wire                          i_SoP,
    input  wire                          i_valid,
    input  wire [`CONV_NB_PIXEL-1:0]     i_pixel,
    input  wire [`CONV_NB_RESULT-1:0]    i_pixelOut,
    input  wire                          i_outValid,
    input  wire                          i_changeBlock,
    input  wire                          i_EoP,
    input  wire                          i_busy,
    input  wire                          i_runDone,
    output int                           o_errorCount,
    output int                           o_framesChecked
);

    logic [`CONV_NB_PIXEL-1:0] linePix [$];
    logic prevValid;
    logic prevEoP;
    logic loadActive;
    logic seenRequest;
    int   outCount;
    int   pulseCount;
    int   frames;
    int   mismatches;
    int   protocolErrors;

    assign o_errorCount    = mismatches + protocolErrors;
    assign o_framesChecked = frames;

    // reference filter, samples before the line start count as zero
    function automatic int modelOut(input int n);
        int acc;
        acc = `CONV_K0 * int'(linePix[n]);
        if (n >= 1) begin
            acc += `CONV_K1 * int'(linePix[n-1]);
        end
        if (n >= 2) begin
            acc += `CONV_K2 * int'(linePix[n-2]);
        end
        return acc;
    endfunction

    task automatic reportMismatch(input string name, input int expected, input int actual);
        mismatches++;
        $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    endtask

    task automatic reportProtocol(input string what);
        protocolErrors++;
        $display("protocol error at %0t ns: %s", $time, what);
    endtask

    always @(posedge i_CLK) begin
        if (i_reset) begin
            linePix.delete();
            prevValid   = 1'b0;
            prevEoP     = 1'b0;
            loadActive  = 1'b0;
            seenRequest = 1'b0;
            outCount    = 0;
            pulseCount  = 0;
        end else begin
            // nothing may move before the first request
            if (!seenRequest && (i_changeBlock || i_EoP || i_outValid || i_busy)) begin
                reportProtocol("outputs active before the first request");
            end
            if (i_load || i_SoP) begin
                seenRequest = 1'b1;
            end

            // load phase mirror, one pixel per rising edge of valid
            if (loadActive && i_valid && !prevValid) begin
                linePix.push_back(i_pixel);
                if (linePix.size() == int'(i_imgLength)) begin
                    loadActive = 1'b0;
                end
            end else if (!loadActive && !i_busy && i_load && !i_SoP) begin
                loadActive = 1'b1;
                linePix.delete();
            end

            if (i_changeBlock) begin
                pulseCount++;
            end
            if (i_EoP && !prevEoP) begin
                if (!i_changeBlock) begin
                    reportProtocol("o_EoP rose without the end of processing pulse");
                end
                outCount = 0;
            end
            if (i_outValid) begin
                if (!i_EoP) begin
                    reportProtocol("o_outValid seen while o_EoP is low");
                end
                if (outCount < linePix.size() && int'(i_pixelOut) != modelOut(outCount)) begin
                    reportMismatch($sformatf("readout value frame %0d sample %0d", frames,
                                   outCount), modelOut(outCount), int'(i_pixelOut));
                end
                outCount++;
            end
            // end of readout closes the frame
            if (!i_EoP && prevEoP) begin
                if (outCount != int'(i_imgLength)) begin
                    reportMismatch($sformatf("readout count frame %0d", frames),
                                   int'(i_imgLength), outCount);
                end
                if (pulseCount != 2) begin
                    reportMismatch($sformatf("changeBlock pulses frame %0d", frames),
                                   2, pulseCount);
                end
                pulseCount = 0;
                frames++;
            end
            prevValid = i_valid;
            prevEoP   = i_EoP;
        end
    end

    always @(posedge i_runDone) begin
        $display("checker: %0d mismatches, %0d protocol errors, %0d frames read back",
                 mismatches, protocolErrors, frames);
    end

endmodule

`default_nettype wire

//--- tb/tbConvAccel.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module tbConvAccel;

    localparam int NB_ADD     = `CONV_NB_ADDRESS;
    localparam int NB_PIX     = `CONV_NB_PIXEL;
    localparam int NUM_FRAMES = 8;
    localparam int MIN_LEN    = 3;
    localparam int MAX_LEN    = 40;
    // about six cycles per pixel and a fixed overhead for each frame
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_LEN * 6 + 200);

    logic                       clk;
    logic                       reset;
    logic [NB_ADD-1:0]          imgLength;
    logic                       load;
    logic                       sop;
    logic                       valid;
    logic [NB_PIX-1:0]          pixel;
    logic [`CONV_NB_RESULT-1:0] pixelOut;
    logic                       outValid;
    logic                       changeBlock;
    logic                       eop;
    logic                       busy;
    logic                       runDone;
    int                         errorCount;
    int                         framesChecked;
    int                         cycleCount;
    int                         frame;
    int                         len;
    integer                     seed;

    tbClock #(.PERIOD_NS(8.0)) u_clock (.o_CLK(clk));

    convAccel dut (
        .i_CLK         (clk),
        .i_reset       (reset),
        .i_imgLength   (imgLength),
        .i_load        (load),
        .i_SoP         (sop),
        .i_valid       (valid),
        .i_pixel       (pixel),
        .o_pixelOut    (pixelOut),
        .o_outValid    (outValid),
        .o_changeBlock (changeBlock),
        .o_EoP         (eop),
        .o_busy        (busy)
    );

    convChecker u_checker (
        .i_CLK (clk), .i_reset (reset), .i_imgLength (imgLength), .i_load (load),
        .i_SoP (sop), .i_valid (valid), .i_pixel (pixel), .i_pixelOut (pixelOut),
        .i_outValid (outValid), .i_changeBlock (changeBlock), .i_EoP (eop), .i_busy (busy),
        .i_runDone (runDone), .o_errorCount (errorCount), .o_framesChecked (framesChecked)
    );

    function automatic int randRange(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // some edges are held high for a few cycles, only the rise counts
    task automatic loadLine(input int n, input bit pokeSoP);
        int i;
        int hold;
        load = 1'b1;
        @(negedge clk);
        while (!busy) @(negedge clk);
        load = 1'b0;
        for (i = 0; i < n; i++) begin
            hold  = (randRange(0, 3) == 0) ? randRange(2, 4) : 1;
            pixel = NB_PIX'(randRange(0, 255));
            valid = 1'b1;
            sop   = pokeSoP && (i == n / 2);
            repeat (hold) @(negedge clk);
            valid = 1'b0;
            sop   = 1'b0;
            repeat (randRange(1, 4)) @(negedge clk);
        end
        while (busy) @(negedge clk);
    endtask

    task automatic processLine(input bit pokeLoad);
        sop = 1'b1;
        @(negedge clk);
        sop = 1'b0;
        if (pokeLoad) begin
            load = 1'b1;
            repeat (3) @(negedge clk);
            load = 1'b0;
        end
        while (!eop) @(negedge clk);
        // DONE hands over to READOUT one cycle later
        @(negedge clk);
    endtask

    task automatic readLine(input int n, input bit pokeLoad);
        int i;
        for (i = 0; i < n; i++) begin
            valid = 1'b1;
            load  = pokeLoad && (i == n / 2);
            @(negedge clk);
            valid = 1'b0;
            load  = 1'b0;
            repeat (randRange(1, 4)) @(negedge clk);
        end
        while (busy) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycleCount);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        seed      = 96466;
        reset     = 1'b1;
        imgLength = '0;
        load      = 1'b0;
        sop       = 1'b0;
        valid     = 1'b0;
        pixel     = '0;
        runDone   = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // quiet window after reset
        repeat (5) @(negedge clk);
        for (frame = 0; frame < NUM_FRAMES; frame++) begin
            len       = randRange(MIN_LEN, MAX_LEN);
            imgLength = NB_ADD'(len);
            @(negedge clk);
            loadLine(len, randRange(0, 1) == 1);
            processLine(randRange(0, 1) == 1);
            readLine(len, randRange(0, 1) == 1);
            repeat (randRange(2, 5)) @(negedge clk);
        end
        runDone = 1'b1;
        @(negedge clk);
        if (errorCount == 0 && framesChecked == NUM_FRAMES) begin
            $display("Finished with no errors");
        end else begin
            if (framesChecked != NUM_FRAMES) begin
                $display("only %0d of %0d frames were read back", framesChecked, NUM_FRAMES);
            end
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- convAccel.f
+incdir+include
src/convPkg.sv
src/imageMem.sv
src/convEngine.sv
src/blockFsm.sv
src/convAccel.sv
tb/tbClock.sv
tb/convChecker.sv
tb/tbConvAccel.sv

//--- run_sim.sh
#!/bin/sh
# builds the convAccel testbench with Verilator and runs it
# the run passes only if the pass line shows up in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f convAccel.f --top-module tbConvAccel -o simConvAccel \
    && ./obj_dir/simConvAccel | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
